// ==== Makefile ====
TOP = simtGroupTb

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== all.f ====
hdl/simtIsaPkg.sv
hdl/simtGroupPkg.sv
hdl/dmaReqIf.sv
hdl/instrDecoder.sv
hdl/simtCore.sv
hdl/fetchSelector.sv
hdl/dmaArbiter.sv
hdl/simtGroup.sv
test/simtGroup_sva.sv
test/simtGroupTb.sv

// ==== hdl/dmaArbiter.sv ====
`timescale 1ns/1ps

module dmaArbiter
    import simtGroupPkg::*;
#(
    parameter int NumCores = 4
)
(
    input  logic                 clk,
    input  logic                 reset,
    dmaReqIf.arbiter             reqs [NumCores],
    output dmaCmdT               dmaCmd,
    output logic [XLen-1:0]      dmaSrc,
    output logic [XLen-1:0]      dmaDst,
    output logic [DmaWidthW-1:0] dmaWidth
);

    logic [NumCores-1:0]  reqVec;
    logic [NumCores-1:0]  grant;
    dmaCmdT               cmdArr   [NumCores];
    logic [XLen-1:0]      srcArr   [NumCores];
    logic [XLen-1:0]      dstArr   [NumCores];
    logic [DmaWidthW-1:0] widthArr [NumCores];
    dmaCmdT               selCmd;
    logic [XLen-1:0]      selSrc;
    logic [XLen-1:0]      selDst;
    logic [DmaWidthW-1:0] selWidth;

    // flatten the request ports
    for (genvar i = 0; i < NumCores; i++)
    begin : g_port
        assign reqVec[i]     = reqs[i].req;
        assign cmdArr[i]     = reqs[i].cmd;
        assign srcArr[i]     = reqs[i].src;
        assign dstArr[i]     = reqs[i].dst;
        assign widthArr[i]   = reqs[i].width;
        assign reqs[i].grant = grant[i];
    end

    //////////////////////////////////////////////////////////////
    // fixed priority, lowest index wins
    //////////////////////////////////////////////////////////////

    always_comb
    begin
        grant = '0;
        for (int i = 0; i < NumCores; i++)
            if (reqVec[i] && grant == '0)
                grant[i] = 1'b1;
    end

    always_comb
    begin
        selCmd   = dmaNone;
        selSrc   = '0;
        selDst   = '0;
        selWidth = '0;
        for (int i = 0; i < NumCores; i++)
        begin
            if (grant[i])
            begin
                selCmd   = cmdArr[i];
                selSrc   = srcArr[i];
                selDst   = dstArr[i];
                selWidth = widthArr[i];
            end
        end
    end

    // winner's command shows on the port for exactly one cycle
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dmaCmd   <= dmaNone;
            dmaSrc   <= '0;
            dmaDst   <= '0;
            dmaWidth <= '0;
        end
        else
        begin
            dmaCmd   <= selCmd;     // dmaNone when nobody was granted
            dmaSrc   <= selSrc;
            dmaDst   <= selDst;
            dmaWidth <= selWidth;
        end
    end

endmodule

// ==== hdl/dmaReqIf.sv ====
`timescale 1ns/1ps

// one core's request toward the DMA arbiter
interface dmaReqIf
    import simtGroupPkg::*;
();

    logic                 req;     // level, high while the DMA instruction is fetched
    dmaCmdT               cmd;
    logic [XLen-1:0]      src;     // rs value
    logic [XLen-1:0]      dst;     // rt value
    logic [DmaWidthW-1:0] width;
    logic                 grant;   // strobe from the arbiter

    modport core (
        output req, cmd, src, dst, width,
        input  grant
    );

    modport arbiter (
        input  req, cmd, src, dst, width,
        output grant
    );

endinterface

// ==== hdl/fetchSelector.sv ====
`timescale 1ns/1ps

module fetchSelector
    import simtGroupPkg::*;
#(
    parameter int NumCores = 4
)
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [NumCores-1:0][XLen-1:0] pcs,
    input  logic [NumCores-1:0]           halted,
    output logic [XLen-1:0]               fetchAddr,
    output logic                          halt
);

    logic [XLen-1:0] minPc;
    logic [XLen-1:0] lastAddr;   // fetch address frozen at group halt

    // lowest pc among the live threads
    always_comb
    begin
        minPc = '1;
        for (int i = 0; i < NumCores; i++)
            if (!halted[i] && pcs[i] < minPc)
                minPc = pcs[i];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            lastAddr <= '0;
        else if (!halt)
            lastAddr <= minPc;
    end

    assign halt      = &halted;   // group done only when every thread is
    assign fetchAddr = halt ? lastAddr : minPc;

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import simtIsaPkg::*, simtGroupPkg::*;
(
    input  logic [XLen-1:0] instr,
    output logic            regWrite,
    output logic            regDst,
    output logic            zeroImm,
    output logic            aluSrc,
    output logic            immToUpper,
    output aluOpT           aluOp,
    output logic            branch,
    output logic            jump,
    output logic            isHalt,
    output dmaCmdT          dmaCmd
);

    opcodeT opcode;
    functT  funct;

    assign opcode = opcodeT'(instr[OpcodeLsb +: OpcodeW]);
    assign funct  = functT'(instr[FunctLsb +: FunctW]);

    always_comb
    begin
        // everything off, unknown opcodes fall through as a no-op
        regWrite   = 1'b0;
        regDst     = 1'b0;
        zeroImm    = 1'b0;
        aluSrc     = 1'b0;
        immToUpper = 1'b0;
        aluOp      = aluAdd;
        branch     = 1'b0;
        jump       = 1'b0;
        isHalt     = 1'b0;
        dmaCmd     = dmaNone;
        case (opcode)
            opRtype:
            begin
                regWrite = 1'b1;
                regDst   = 1'b1;
                case (funct)
                    functAdd: aluOp = aluAdd;
                    functSub: aluOp = aluSub;
                    functAnd: aluOp = aluAnd;
                    functOr:  aluOp = aluOr;
                    functSlt: aluOp = aluSlt;
                    default:  regWrite = 1'b0;   // bad funct, no write
                endcase
            end
            opAddi:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opAndi:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                zeroImm  = 1'b1;
                aluOp    = aluAnd;
            end
            opOri:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                zeroImm  = 1'b1;
                aluOp    = aluOr;
            end
            opLui:
            begin
                regWrite   = 1'b1;
                immToUpper = 1'b1;
            end
            opBeq:
            begin
                branch = 1'b1;
                aluOp  = aluSub;   // equal when the difference is zero
            end
            opJ:    jump   = 1'b1;
            opHalt: isHalt = 1'b1;
            opD2s:  dmaCmd = dmaD2s;
            opS2d:  dmaCmd = dmaS2d;
            default: ;
        endcase
    end

endmodule

// ==== hdl/simtCore.sv ====
`timescale 1ns/1ps

module simtCore
    import simtIsaPkg::*, simtGroupPkg::*;
#(
    parameter int ThreadId = 0
)
(
    input  logic            clk,
    input  logic            reset,
    input  logic            dmaStall,
    input  logic [XLen-1:0] fetchAddr,
    input  logic [XLen-1:0] instr,
    output logic [XLen-1:0] pc,
    output logic            halted,
    dmaReqIf.core           dma
);

    logic [XLen-1:0]     regFile [RegCount];
    logic [RegAddrW-1:0] rsAddr;
    logic [RegAddrW-1:0] rtAddr;
    logic [RegAddrW-1:0] rdAddr;
    logic [RegAddrW-1:0] wrAddr;
    logic [XLen-1:0]     rsVal;
    logic [XLen-1:0]     rtVal;
    logic [XLen-1:0]     immExt;
    logic [XLen-1:0]     srcB;
    logic [XLen-1:0]     aluResult;
    logic [XLen-1:0]     wrData;
    logic [XLen-1:0]     pcPlus4;
    logic [XLen-1:0]     branchTarget;
    logic [XLen-1:0]     jumpTarget;
    logic [XLen-1:0]     nextPc;
    logic                regWrite;
    logic                regDst;
    logic                zeroImm;
    logic                aluSrc;
    logic                immToUpper;
    logic                branch;
    logic                jump;
    logic                isHalt;
    aluOpT               aluOp;
    dmaCmdT              dmaCmd;
    logic                active;
    logic                isDma;
    logic                retire;

    instrDecoder u_instrDecoder (
        .instr      (instr),
        .regWrite   (regWrite),
        .regDst     (regDst),
        .zeroImm    (zeroImm),
        .aluSrc     (aluSrc),
        .immToUpper (immToUpper),
        .aluOp      (aluOp),
        .branch     (branch),
        .jump       (jump),
        .isHalt     (isHalt),
        .dmaCmd     (dmaCmd)
    );

    //////////////////////////////////////////////////////////////
    // operands and ALU
    //////////////////////////////////////////////////////////////

    assign rsAddr = instr[RsLsb +: RegAddrW];
    assign rtAddr = instr[RtLsb +: RegAddrW];
    assign rdAddr = instr[RdLsb +: RegAddrW];
    assign rsVal  = regFile[rsAddr];
    assign rtVal  = regFile[rtAddr];

    // andi and ori take the immediate zero extended
    assign immExt = zeroImm ? {{(XLen-ImmW){1'b0}}, instr[ImmLsb +: ImmW]}
                            : {{(XLen-ImmW){instr[ImmLsb+ImmW-1]}}, instr[ImmLsb +: ImmW]};
    assign srcB   = aluSrc ? immExt : rtVal;

    always_comb
    begin
        case (aluOp)
            aluSub:  aluResult = rsVal - srcB;
            aluAnd:  aluResult = rsVal & srcB;
            aluOr:   aluResult = rsVal | srcB;
            aluSlt:  aluResult = {{(XLen-1){1'b0}}, $signed(rsVal) < $signed(srcB)};
            default: aluResult = rsVal + srcB;
        endcase
    end

    assign wrData = immToUpper ? {instr[ImmLsb +: ImmW], {(XLen-ImmW){1'b0}}} : aluResult;
    assign wrAddr = regDst ? rdAddr : rtAddr;

    // next pc
    assign pcPlus4      = pc + XLen'(4);
    assign branchTarget = pcPlus4 + {immExt[XLen-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[XLen-1:TargetW+2], instr[TargetLsb +: TargetW], 2'b00};

    always_comb
    begin
        if (jump)
            nextPc = jumpTarget;
        else if (branch && aluResult == '0)
            nextPc = branchTarget;
        else if (isHalt)
            nextPc = pc;   // a halted thread parks on its halt
        else
            nextPc = pcPlus4;
    end

    // this thread runs only when the shared fetch is its own pc
    assign active = !dmaStall && !halted && (pc == fetchAddr);
    assign isDma  = (dmaCmd != dmaNone);
    assign retire = active && (!isDma || dma.grant);   // losers retry next cycle

    assign dma.req   = active && isDma;
    assign dma.cmd   = dmaCmd;
    assign dma.src   = rsVal;
    assign dma.dst   = rtVal;
    assign dma.width = instr[ImmLsb +: DmaWidthW];

    //////////////////////////////////////////////////////////////
    // architectural state
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc     <= '0;
            halted <= 1'b0;
        end
        else if (retire)
        begin
            pc <= nextPc;
            if (isHalt)
                halted <= 1'b1;
        end
    end

    // r1 starts at the thread number so a beq can split threads
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < RegCount; i++)
                regFile[i] <= (i == 1) ? XLen'(ThreadId) : '0;
        end
        else if (retire && regWrite && wrAddr != '0)
            regFile[wrAddr] <= wrData;   // r0 stays zero
    end

endmodule

// ==== hdl/simtGroup.sv ====
`timescale 1ns/1ps

module simtGroup
    import simtGroupPkg::*;
#(
    parameter int NumCores = 4
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dmaStall,
    input  logic [XLen-1:0]      instr,      // async imem read of fetchAddr
    output logic [XLen-1:0]      fetchAddr,
    output dmaCmdT               dmaCmd,
    output logic [XLen-1:0]      dmaSrc,
    output logic [XLen-1:0]      dmaDst,
    output logic [DmaWidthW-1:0] dmaWidth,
    output logic                 halt
);

    logic [NumCores-1:0][XLen-1:0] pcs;
    logic [NumCores-1:0]           halted;

    dmaReqIf dmaBus [NumCores] ();

    // thread cores, all see the same fetched word
    for (genvar i = 0; i < NumCores; i++)
    begin : g_core
        simtCore #(
            .ThreadId (i)
        ) u_simtCore (
            .clk       (clk),
            .reset     (reset),
            .dmaStall  (dmaStall),
            .fetchAddr (fetchAddr),
            .instr     (instr),
            .pc        (pcs[i]),
            .halted    (halted[i]),
            .dma       (dmaBus[i])
        );
    end

    fetchSelector #(
        .NumCores (NumCores)
    ) u_fetchSelector (
        .clk       (clk),
        .reset     (reset),
        .pcs       (pcs),
        .halted    (halted),
        .fetchAddr (fetchAddr),
        .halt      (halt)
    );

    dmaArbiter #(
        .NumCores (NumCores)
    ) u_dmaArbiter (
        .clk      (clk),
        .reset    (reset),
        .reqs     (dmaBus),
        .dmaCmd   (dmaCmd),
        .dmaSrc   (dmaSrc),
        .dmaDst   (dmaDst),
        .dmaWidth (dmaWidth)
    );

endmodule

// ==== hdl/simtGroupPkg.sv ====
package simtGroupPkg;

    //////////////////////////////////////////////////////////////
    // datapath and DMA port widths
    //////////////////////////////////////////////////////////////

    localparam int XLen      = 32;   // data and address width
    localparam int DmaWidthW = 10;   // transfer length field

    // command placed on the shared DMA port
    typedef enum logic [1:0] {
        dmaNone = 2'b00,
        dmaD2s  = 2'b01,
        dmaS2d  = 2'b10
    } dmaCmdT;

endpackage

// ==== hdl/simtIsaPkg.sv ====
package simtIsaPkg;

    //////////////////////////////////////////////////////////////
    // instruction word layout
    //////////////////////////////////////////////////////////////

    localparam int OpcodeW   = 6;
    localparam int FunctW    = 6;
    localparam int RegAddrW  = 5;
    localparam int RegCount  = 32;
    localparam int ImmW      = 16;
    localparam int TargetW   = 26;

    localparam int OpcodeLsb = 26;
    localparam int RsLsb     = 21;
    localparam int RtLsb     = 16;
    localparam int RdLsb     = 11;
    localparam int FunctLsb  = 0;
    localparam int ImmLsb    = 0;
    localparam int TargetLsb = 0;

    typedef enum logic [OpcodeW-1:0] {
        opRtype = 6'b000000,
        opJ     = 6'b000010,
        opBeq   = 6'b000100,
        opAddi  = 6'b001000,
        opAndi  = 6'b001100,
        opOri   = 6'b001101,
        opHalt  = 6'b001110,
        opLui   = 6'b001111,
        opD2s   = 6'b110001,   // dram to sram
        opS2d   = 6'b111001    // sram to dram
    } opcodeT;

    typedef enum logic [FunctW-1:0] {
        functAdd = 6'b100000,
        functSub = 6'b100010,
        functAnd = 6'b100100,
        functOr  = 6'b100101,
        functSlt = 6'b101010
    } functT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

endpackage

// ==== test/simtGroupTb.sv ====
`timescale 1ns/1ps

module simtGroupTb
    import simtIsaPkg::*, simtGroupPkg::*;
();

    localparam int NumCores      = 4;
    localparam int ProgLen       = 40;
    localparam int TimeoutCycles = 2000;
    localparam logic [XLen-1:0] HaltWord = {opHalt, 26'd0};

    typedef struct packed {
        dmaCmdT               cmd;
        logic [XLen-1:0]      src;
        logic [XLen-1:0]      dst;
        logic [DmaWidthW-1:0] width;
    } dmaRecT;

    logic                 clk;
    logic                 reset;
    logic                 dmaStall;
    logic [XLen-1:0]      instr;
    logic [XLen-1:0]      fetchAddr;
    dmaCmdT               dmaCmd;
    logic [XLen-1:0]      dmaSrc;
    logic [XLen-1:0]      dmaDst;
    logic [DmaWidthW-1:0] dmaWidth;
    logic                 halt;

    logic [XLen-1:0]      imem [ProgLen];
    logic [31:0]          lfsr;
    string                testName;
    bit                   verdictShown;

    // reference model state
    logic [XLen-1:0]      mReg [NumCores][32];
    logic [XLen-1:0]      mPc [NumCores];
    logic [NumCores-1:0]  mHalted;
    logic [XLen-1:0]      lastFetch;
    dmaRecT               expRec;      // DMA port contents expected next cycle
    logic                 prevStall;
    dmaRecT               curSeq [$];
    dmaRecT               refSeq [$];
    dmaRecT               plainSeq [$];

    simtGroup #(
        .NumCores (NumCores)
    ) u_simtGroup (
        .clk       (clk),
        .reset     (reset),
        .dmaStall  (dmaStall),
        .instr     (instr),
        .fetchAddr (fetchAddr),
        .dmaCmd    (dmaCmd),
        .dmaSrc    (dmaSrc),
        .dmaDst    (dmaDst),
        .dmaWidth  (dmaWidth),
        .halt      (halt)
    );

    always #10 clk = ~clk;

    // async instruction memory that returns halt outside the program
    assign instr = (fetchAddr < ProgLen * 4) ? imem[fetchAddr[7:2]] : HaltWord;

    //////////////////////////////////////////////////////////////
    // random numbers and program generation
    //////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = nextLfsr(lfsr);
            r = {r[30:0], lfsr[0]};   // one step per bit
        end
        return r;
    endfunction

    function automatic logic [31:0] rType(input functT f, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {opRtype, rs, rt, rd, 5'b00000, f};
    endfunction

    function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] randInstr(input bit dmaOnly);
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [15:0] imm;
        kind = 4'(randBits(4));
        rs   = 5'(randBits(3));
        rt   = 5'(randBits(3));
        dest = 5'(randBits(3));
        imm  = 16'(randBits(16));
        if (dest == 5'd1)
            dest = 5'd0;   // r1 keeps the thread id while r0 writes get exercised
        if (dmaOnly)
            kind = 4'd10;
        case (kind)
            4'd0:                return rType(functAdd, rs, rt, dest);
            4'd1:                return rType(functSub, rs, rt, dest);
            4'd2:                return rType(functAnd, rs, rt, dest);
            4'd3:                return rType(functOr, rs, rt, dest);
            4'd4:                return rType(functSlt, rs, rt, dest);
            4'd7:                return iType(opAndi, rs, dest, imm);
            4'd8:                return iType(opOri, rs, dest, imm);
            4'd9:                return iType(opLui, 5'd0, dest, imm);
            4'd10, 4'd11, 4'd12: return iType(imm[15] ? opS2d : opD2s, rs, rt, {7'd0, imm[8:0]});
            default:             return iType(opAddi, rs, dest, imm);
        endcase
    endfunction

    task automatic buildProgram();
        imem[0] = iType(opD2s, 5'd1, 5'(randBits(3)), 16'(randBits(9)));   // all threads at once
        for (int i = 1; i < 10; i++)
            imem[i] = randInstr(1'b0);
        imem[10] = iType(opAddi, 5'd0, 5'd8, 16'(randBits(2)));
        imem[11] = iType(opBeq, 5'd1, 5'd8, 16'd4);   // one thread jumps ahead to 16
        for (int i = 12; i < 20; i++)
            imem[i] = randInstr(i == 13 || i == 15);
        imem[20] = {opJ, 26'd24};
        // skipped by the jump and marked by width 3ff
        for (int i = 21; i < 24; i++)
            imem[i] = iType(opS2d, 5'(randBits(3)), 5'(randBits(3)), 16'h03ff);
        for (int i = 24; i < ProgLen - 1; i++)
            imem[i] = randInstr(1'b0);
        imem[ProgLen-1] = HaltWord;
    endtask

    //////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        if (addr < ProgLen * 4)
            return imem[addr[7:2]];
        return HaltWord;
    endfunction

    function automatic logic [31:0] modelFetch();
        logic [31:0] m;
        if (&mHalted)
            return lastFetch;
        m = '1;
        for (int c = 0; c < NumCores; c++)
            if (!mHalted[c] && mPc[c] < m)
                m = mPc[c];
        return m;
    endfunction

    task automatic resetModel();
        for (int c = 0; c < NumCores; c++)
        begin
            mPc[c] = '0;
            for (int r = 0; r < 32; r++)
                mReg[c][r] = (r == 1) ? 32'(c) : 32'd0;
        end
        mHalted   = '0;
        lastFetch = '0;
        expRec    = '0;
        prevStall = 1'b0;
    endtask

    task automatic execInstr(input int c, input logic [31:0] ins, inout bit granted);
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] pcPlus4;
        logic [31:0] nextPc;
        logic [31:0] val;
        logic [4:0]  dest;
        bit          wr;
        rsV     = mReg[c][ins[25:21]];
        rtV     = mReg[c][ins[20:16]];
        sImm    = {{16{ins[15]}}, ins[15:0]};
        zImm    = {16'd0, ins[15:0]};
        pcPlus4 = mPc[c] + 32'd4;
        nextPc  = pcPlus4;
        dest    = ins[20:16];
        val     = '0;
        wr      = 1'b1;
        case (ins[31:26])
            opRtype:
            begin
                dest = ins[15:11];
                case (ins[5:0])
                    functAdd: val = rsV + rtV;
                    functSub: val = rsV - rtV;
                    functAnd: val = rsV & rtV;
                    functOr:  val = rsV | rtV;
                    functSlt: val = 32'($signed(rsV) < $signed(rtV));
                    default:  wr = 1'b0;
                endcase
            end
            opAddi: val = rsV + sImm;
            opAndi: val = rsV & zImm;
            opOri:  val = rsV | zImm;
            opLui:  val = {ins[15:0], 16'd0};
            opD2s, opS2d:
            begin
                wr = 1'b0;
                if (!granted)
                begin
                    granted = 1'b1;
                    expRec  = '{(ins[31:26] == opD2s) ? dmaD2s : dmaS2d, rsV, rtV, ins[9:0]};
                end
                else
                    nextPc = mPc[c];   // lost arbitration so retry next cycle
            end
            default:
            begin
                wr = 1'b0;
                if (ins[31:26] == opBeq && rsV == rtV)
                    nextPc = pcPlus4 + (sImm << 2);
                else if (ins[31:26] == opJ)
                    nextPc = {pcPlus4[31:28], ins[25:0], 2'b00};
                else if (ins[31:26] == opHalt)
                begin
                    mHalted[c] = 1'b1;
                    nextPc     = mPc[c];
                end
            end
        endcase
        if (wr && dest != 5'd0)
            mReg[c][dest] = val;
        mPc[c] = nextPc;
    endtask

    task automatic stepModel(input logic stall);
        logic [31:0] fetch;
        logic [31:0] ins;
        bit          granted;
        fetch   = modelFetch();
        ins     = fetchWord(fetch);
        granted = 1'b0;
        expRec  = '0;
        // lowest index goes first so it wins the DMA port
        for (int c = 0; c < NumCores; c++)
            if (!stall && !mHalted[c] && mPc[c] == fetch)
                execInstr(c, ins, granted);
        lastFetch = fetch;
    endtask

    //////////////////////////////////////////////////////////////
    // checking and run control
    //////////////////////////////////////////////////////////////

    task automatic expectEqual(input string what, input logic [31:0] expVal,
                               input logic [31:0] actVal);
        if (expVal !== actVal)
        begin
            $display("ERR %s %s expected %h actual %h", testName, what, expVal, actVal);
            verdictShown = 1'b1;
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic runProgram(input bit withStall);
        int cycles;
        int afterHalt;
        curSeq.delete();
        refSeq.delete();
        @(posedge clk);
        #1;
        reset    = 1'b1;
        dmaStall = 1'b0;
        resetModel();
        repeat (10) @(posedge clk);
        #1;
        reset     = 1'b0;
        cycles    = 0;
        afterHalt = 0;
        while (afterHalt < 6)   // a few cycles past halt to see the group stay parked
        begin
            if (cycles == TimeoutCycles)
            begin
                $display("%s: halt never rose within %0d cycles", testName, TimeoutCycles);
                verdictShown = 1'b1;
                $display("Verification failed");
                $fatal(1);
            end
            dmaStall = withStall ? (randBits(2) == 32'd0) : 1'b0;
            @(negedge clk);
            expectEqual("fetchAddr", modelFetch(), fetchAddr);
            expectEqual("halt", 32'(&mHalted), 32'(halt));
            expectEqual("dmaCmd", 32'(expRec.cmd), 32'(dmaCmd));
            expectEqual("dmaSrc", expRec.src, dmaSrc);
            expectEqual("dmaDst", expRec.dst, dmaDst);
            expectEqual("dmaWidth", 32'(expRec.width), 32'(dmaWidth));
            if (prevStall)
                expectEqual("dmaCmd after stall", 32'(dmaNone), 32'(dmaCmd));
            if (dmaCmd != dmaNone)
                curSeq.push_back(dmaRecT'{dmaCmd, dmaSrc, dmaDst, dmaWidth});
            stepModel(dmaStall);
            if (expRec.cmd != dmaNone)
                refSeq.push_back(expRec);
            prevStall = dmaStall;
            @(posedge clk);
            #1;
            cycles++;
            if (halt)
                afterHalt++;
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        dmaStall     = 1'b0;
        lfsr         = 32'hae4e;
        verdictShown = 1'b0;
        testName     = "setup";
        buildProgram();

        testName = "plain run";
        runProgram(1'b0);
        plainSeq = refSeq;
        // first command ran on all threads with rs = r1
        for (int i = 0; i < NumCores; i++)
            expectEqual("arbitration order src", 32'(i), curSeq[i].src);
        foreach (curSeq[i])
            expectEqual("jumped-over dma", 32'd0, 32'(curSeq[i].width == 10'h3ff));

        testName = "stall run";
        runProgram(1'b1);
        expectEqual("dma count vs plain run", 32'(plainSeq.size()), 32'(curSeq.size()));
        foreach (plainSeq[i])
        begin
            expectEqual("seq cmd", 32'(plainSeq[i].cmd), 32'(curSeq[i].cmd));
            expectEqual("seq src", plainSeq[i].src, curSeq[i].src);
            expectEqual("seq dst", plainSeq[i].dst, curSeq[i].dst);
            expectEqual("seq width", 32'(plainSeq[i].width), 32'(curSeq[i].width));
        end

        verdictShown = 1'b1;
        $display("Verification passed");
        $finish;
    end

    final
    begin
        if (!verdictShown)
            $display("Verification failed");
    end

endmodule

// ==== test/simtGroup_sva.sv ====
`timescale 1ns/1ps

module simtGroupSva
    import simtGroupPkg::*;
#(
    parameter int NumCores = 4
)
(
    input logic                clk,
    input logic                reset,
    input logic [NumCores-1:0] reqVec,
    input logic [NumCores-1:0] grant,
    input dmaCmdT              dmaCmd,
    input logic                halt
);

    //////////////////////////////////////////////////////////////
    // DMA arbiter
    //////////////////////////////////////////////////////////////

    grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("DMA grant has more than one bit set");

    grantToRequester: assert property (@(posedge clk) disable iff (reset)
        (grant & ~reqVec) == '0)
        else $error("DMA grant given to a core that is not requesting");

    // port idle after a cycle without a winner
    idleAfterNoGrant: assert property (@(posedge clk) disable iff (reset)
        (grant == '0) |=> (dmaCmd == dmaNone))
        else $error("DMA command on the port without a grant the cycle before");

    //////////////////////////////////////////////////////////////
    // group halt
    //////////////////////////////////////////////////////////////

    haltSticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
        else $error("group halt fell before reset");

endmodule

bind simtGroup simtGroupSva #(
    .NumCores (NumCores)
) u_simtGroupSva (
    .clk    (clk),
    .reset  (reset),
    .reqVec (u_dmaArbiter.reqVec),
    .grant  (u_dmaArbiter.grant),
    .dmaCmd (dmaCmd),
    .halt   (halt)
);
